// File: mini_rv.f
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
run_control.sv
fetch_issue.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
mem_writeback.sv
mini_rv_core.sv
tb_mini_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mini_rv testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_mini_rv_core \
  -f mini_rv.f --Mdir obj_dir -o sim_mini_rv > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_mini_rv > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: tb_mini_rv_core.sv
// testbench for the mini_rv core
// memory models, small programs built by encoder functions, store checks by assertion
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module tb_mini_rv_core import rv_isa_pkg::*; ;

  localparam int CLK_PERIOD  = 20;
  localparam int MAX_WORDS   = 16; // room for the longest program
  localparam int NUM_PROGS   = 4;
  localparam int WATCHDOG_NS = 40 * MAX_WORDS * NUM_PROGS * CLK_PERIOD;

  logic             clock = 1'b0;
  logic             rst_n;
  logic             start;
  logic [`XLEN-1:0] program_address;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;
  logic             dmem_we;
  logic             dmem_re;
  logic [`XLEN-1:0] dmem_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_load [$];
  integer      seed;
  int          errors = 0;
  logic        idle_phase = 1'b0;

  mini_rv_core i_dut (
    .clock           (clock),
    .rst_n           (rst_n),
    .start           (start),
    .program_address (program_address),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .dmem_addr       (dmem_addr),
    .dmem_wdata      (dmem_wdata),
    .dmem_we         (dmem_we),
    .dmem_re         (dmem_re),
    .dmem_rdata      (dmem_rdata)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clock)
  begin
    if (dmem_we)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  // idle core must not touch data memory
  always @(negedge clock)
  begin
    if (idle_phase)
    begin
      assert (!dmem_we && !dmem_re)
      else
      begin
        errors++;
        $display("[ERROR] dmem_we/dmem_re got %h/%h expected 0/0", dmem_we, dmem_re);
      end
    end
  end

  always @(negedge clock)
  begin
    if (rst_n && !idle_phase && dmem_we)
    begin
      assert (exp_addr.size() > 0)
      else
      begin
        errors++;
        $display("unexpected store to address %h", dmem_addr);
      end
      if (exp_addr.size() > 0)
      begin
        assert (dmem_addr == exp_addr[0])
        else
        begin
          errors++;
          $display("[ERROR] dmem_addr got %h expected %h", dmem_addr, exp_addr[0]);
        end
        assert (dmem_wdata == exp_data[0])
        else
        begin
          errors++;
          $display("[ERROR] dmem_wdata got %h expected %h", dmem_wdata, exp_data[0]);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  always @(negedge clock)
  begin
    if (rst_n && !idle_phase && dmem_re)
    begin
      assert (exp_load.size() > 0)
      else
      begin
        errors++;
        $display("unexpected load from address %h", dmem_addr);
      end
      if (exp_load.size() > 0)
      begin
        assert (dmem_addr == exp_load[0])
        else
        begin
          errors++;
          $display("[ERROR] dmem_addr got %h expected %h", dmem_addr, exp_load[0]);
        end
        void'(exp_load.pop_front());
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the core stopped making progress");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    instr_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = opc;
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    instr_u w;
    w.i_fmt.imm12  = imm;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = opc;
    return w;
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return r_type(imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE);
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return r_type({imm[12], imm[10:5]}, rs2, rs1, f3, {imm[4:1], imm[11]}, OPC_BRANCH);
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic expect_load(input logic [31:0] addr);
    exp_load.push_back(addr);
  endtask

  task automatic check_fetch(input logic [31:0] expected);
    assert (imem_addr == expected)
    else
    begin
      errors++;
      $display("[ERROR] imem_addr got %h expected %h", imem_addr, expected);
    end
  endtask

  task automatic run_program(input logic [31:0] base);
    int i;
    int waited;
    rst_n           = 1'b0;
    start           = 1'b0;
    program_address = base;
    // every word a store whose offset is its own address
    for (i = 0; i < 256; i++)
      imem[i] = s_type(12'(i * 4), 5'(i), 5'd0);
    prog.push_back(b_type(13'd0, 5'd0, 5'd0, F3_BEQ)); // self loop
    repeat (2) @(negedge clock);
    idle_phase <= 1'b1;
    repeat (2) @(negedge clock);
    rst_n = 1'b1;
    repeat (3) @(negedge clock);
    // program words show up only once start is driven
    for (i = 0; i < prog.size(); i++)
      imem[int'(base[9:2]) + i] = prog[i];
    idle_phase <= 1'b0;
    start = 1'b1;
    @(negedge clock);
    start = 1'b0;
    check_fetch(base);
    @(negedge clock);
    check_fetch(base + 32'd4);
    @(negedge clock);
    check_fetch(base + 32'd8);
    waited = 0;
    while ((exp_addr.size() > 0 || exp_load.size() > 0) && waited < 40 * prog.size())
    begin
      @(negedge clock);
      waited++;
    end
    if (exp_addr.size() > 0)
    begin
      errors++;
      $display("%0d stores never happened in program at %h", exp_addr.size(), base);
      exp_addr.delete();
      exp_data.delete();
    end
    if (exp_load.size() > 0)
    begin
      errors++;
      $display("%0d loads never happened in program at %h", exp_load.size(), base);
      exp_load.delete();
    end
    repeat (8) @(negedge clock); // catches stray stores
    prog.delete();
  endtask

  task automatic forward_chain();
    logic [11:0] a;
    logic [11:0] b;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] x4;
    logic [31:0] x5;
    logic [31:0] x6;
    a  = 12'($random(seed));
    b  = 12'($random(seed));
    x1 = sext12(a);
    x2 = x1 + sext12(b);
    x3 = x2 + x1;
    x4 = x3 - x1;
    x5 = x4 ^ x2;
    x6 = ($signed(x5) < $signed(x3)) ? 32'd1 : 32'd0;
    prog.push_back(i_type(a, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
    prog.push_back(i_type(b, 5'd1, F3_ADD_SUB, 5'd2, OPC_OP_IMM));
    prog.push_back(r_type(F7_BASE, 5'd1, 5'd2, F3_ADD_SUB, 5'd3, OPC_OP));
    prog.push_back(r_type(F7_ALT, 5'd1, 5'd3, F3_ADD_SUB, 5'd4, OPC_OP)); // x1 from wb
    prog.push_back(r_type(F7_BASE, 5'd2, 5'd4, F3_XOR, 5'd5, OPC_OP));
    prog.push_back(r_type(F7_BASE, 5'd3, 5'd5, F3_SLT, 5'd6, OPC_OP));
    prog.push_back(s_type(12'h100, 5'd2, 5'd0));
    prog.push_back(s_type(12'h104, 5'd3, 5'd0));
    prog.push_back(s_type(12'h108, 5'd4, 5'd0));
    prog.push_back(s_type(12'h10c, 5'd5, 5'd0));
    prog.push_back(s_type(12'h110, 5'd6, 5'd0));
    expect_store(32'h100, x2);
    expect_store(32'h104, x3);
    expect_store(32'h108, x4);
    expect_store(32'h10c, x5);
    expect_store(32'h110, x6);
    run_program(32'h40);
  endtask

  task automatic load_use();
    logic [31:0] word;
    logic [11:0] c;
    word = $random(seed);
    c    = 12'($random(seed));
    dmem[32'h200 >> 2] = word;
    prog.push_back(i_type(c, 5'd0, F3_ADD_SUB, 5'd9, OPC_OP_IMM));
    prog.push_back(i_type(12'h200, 5'd0, F3_WORD, 5'd7, OPC_LOAD));
    prog.push_back(r_type(F7_BASE, 5'd9, 5'd7, F3_ADD_SUB, 5'd8, OPC_OP));
    prog.push_back(s_type(12'h120, 5'd8, 5'd0));
    expect_load(32'h200);
    expect_store(32'h120, word + sext12(c));
    run_program(32'h80);
  endtask

  task automatic branch_flow();
    prog.push_back(i_type(12'd5, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
    prog.push_back(i_type(12'd5, 5'd0, F3_ADD_SUB, 5'd11, OPC_OP_IMM));
    prog.push_back(b_type(13'd12, 5'd11, 5'd10, F3_BEQ)); // taken, skips two
    prog.push_back(i_type(12'd99, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
    prog.push_back(i_type(12'd77, 5'd0, F3_ADD_SUB, 5'd11, OPC_OP_IMM));
    prog.push_back(b_type(13'd8, 5'd11, 5'd10, F3_BNE)); // falls through
    prog.push_back(i_type(12'd33, 5'd0, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    prog.push_back(s_type(12'h130, 5'd10, 5'd0));
    prog.push_back(s_type(12'h134, 5'd11, 5'd0));
    prog.push_back(s_type(12'h138, 5'd12, 5'd0));
    expect_store(32'h130, 32'd5);
    expect_store(32'h134, 32'd5);
    expect_store(32'h138, 32'd33);
    run_program(32'hc0);
  endtask

  task automatic random_immediates();
    logic [11:0] r;
    logic [19:0] u;
    logic [4:0]  sh1;
    logic [4:0]  sh2;
    logic [4:0]  sh3;
    logic [31:0] x13;
    logic [31:0] x14;
    r   = 12'($random(seed));
    u   = 20'($random(seed)) | 20'h8_0000; // negative, so srai and srli differ
    sh1 = 5'($random(seed));
    sh2 = 5'($random(seed)) | 5'd1;
    sh3 = 5'($random(seed)) | 5'd1;
    x13 = sext12(r);
    x14 = {u, 12'b0};
    prog.push_back(i_type(r, 5'd0, F3_ADD_SUB, 5'd13, OPC_OP_IMM));
    prog.push_back({u, 5'd14, OPC_LUI});
    prog.push_back(i_type({F7_BASE, sh1}, 5'd13, F3_SLL, 5'd15, OPC_OP_IMM));
    prog.push_back(i_type({F7_ALT, sh2}, 5'd14, F3_SRL_SRA, 5'd16, OPC_OP_IMM));
    prog.push_back(i_type({F7_BASE, sh3}, 5'd14, F3_SRL_SRA, 5'd17, OPC_OP_IMM));
    for (int k = 0; k < 5; k++)
      prog.push_back(s_type(12'(12'h140 + 4 * k), 5'(13 + k), 5'd0));
    expect_store(32'h140, x13);
    expect_store(32'h144, x14);
    expect_store(32'h148, x13 << sh1);
    expect_store(32'h14c, 32'($signed(x14) >>> sh2));
    expect_store(32'h150, x14 >> sh3);
    run_program(32'h100);
  endtask

  initial
  begin
    seed            = 32'h512d;
    rst_n           = 1'b0;
    start           = 1'b0;
    program_address = '0;
    for (int i = 0; i < 256; i++)
      dmem[i] = 32'hd000_0000 | 32'(i * 4);
    forward_chain();
    load_use();
    branch_flow();
    random_immediates();
    $display("checks done, errors: %0d", errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: mini_rv_core.sv
// mini_rv core top level
// five-stage RV32I subset pipeline with simple always-ready memory ports
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module mini_rv_core import rv_isa_pkg::*, core_pipe_pkg::*; (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             start,
  input  logic [`XLEN-1:0] program_address,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  output logic             dmem_we,
  output logic             dmem_re,
  input  logic [`XLEN-1:0] dmem_rdata
);

  logic                   running;
  logic                   launch;
  logic                   stall;
  logic                   redirect;
  logic [`XLEN-1:0]       redirect_pc;
  instr_u                 id_instr;
  logic [`XLEN-1:0]       id_pc;
  fwd_sel_e               fwd_rs1;
  fwd_sel_e               fwd_rs2;
  logic [`XLEN-1:0]       ex_pc;
  logic [`XLEN-1:0]       ex_rs1_val;
  logic [`XLEN-1:0]       ex_rs2_val;
  logic [`XLEN-1:0]       ex_imm;
  logic [`REG_ADDR_W-1:0] ex_rd;
  alu_op_e                ex_alu_op;
  logic                   ex_use_imm;
  logic                   ex_reg_write;
  logic                   ex_load;
  logic                   ex_store;
  logic                   ex_branch;
  logic                   ex_branch_ne;
  logic [`XLEN-1:0]       ex_result;
  logic [`XLEN-1:0]       mem_addr;
  logic [`XLEN-1:0]       mem_store_data;
  logic [`REG_ADDR_W-1:0] mem_rd;
  logic                   mem_reg_write;
  logic                   mem_load;
  logic                   mem_store;
  logic [`XLEN-1:0]       mem_result;
  logic                   wb_we;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  run_control i_run_control (
    .clock   (clock),
    .rst_n   (rst_n),
    .start   (start),
    .running (running),
    .launch  (launch)
  );

  fetch_issue i_fetch_issue (
    .clock           (clock),
    .rst_n           (rst_n),
    .running         (running),
    .launch          (launch),
    .stall           (stall),
    .redirect        (redirect),
    .program_address (program_address),
    .redirect_pc     (redirect_pc),
    .imem_data       (imem_data),
    .imem_addr       (imem_addr),
    .id_instr        (id_instr),
    .id_pc           (id_pc)
  );

  hazard_unit i_hazard_unit (
    .id_instr      (id_instr),
    .ex_rd         (ex_rd),
    .mem_rd        (mem_rd),
    .wb_rd         (wb_rd),
    .ex_reg_write  (ex_reg_write),
    .mem_reg_write (mem_reg_write),
    .wb_we         (wb_we),
    .ex_load       (ex_load),
    .stall         (stall),
    .fwd_rs1       (fwd_rs1),
    .fwd_rs2       (fwd_rs2)
  );

  // a taken branch also flushes the decode-to-execute register
  decode_unit i_decode_unit (
    .clock        (clock),
    .rst_n        (rst_n),
    .stall        (stall),
    .flush        (redirect),
    .id_instr     (id_instr),
    .id_pc        (id_pc),
    .fwd_rs1      (fwd_rs1),
    .fwd_rs2      (fwd_rs2),
    .ex_result    (ex_result),
    .mem_result   (mem_result),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .ex_pc        (ex_pc),
    .ex_rs1_val   (ex_rs1_val),
    .ex_rs2_val   (ex_rs2_val),
    .ex_imm       (ex_imm),
    .ex_rd        (ex_rd),
    .ex_alu_op    (ex_alu_op),
    .ex_use_imm   (ex_use_imm),
    .ex_reg_write (ex_reg_write),
    .ex_load      (ex_load),
    .ex_store     (ex_store),
    .ex_branch    (ex_branch),
    .ex_branch_ne (ex_branch_ne)
  );

  execute_unit i_execute_unit (
    .clock          (clock),
    .rst_n          (rst_n),
    .ex_pc          (ex_pc),
    .ex_rs1_val     (ex_rs1_val),
    .ex_rs2_val     (ex_rs2_val),
    .ex_imm         (ex_imm),
    .ex_rd          (ex_rd),
    .ex_alu_op      (ex_alu_op),
    .ex_use_imm     (ex_use_imm),
    .ex_reg_write   (ex_reg_write),
    .ex_load        (ex_load),
    .ex_store       (ex_store),
    .ex_branch      (ex_branch),
    .ex_branch_ne   (ex_branch_ne),
    .ex_result      (ex_result),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .mem_addr       (mem_addr),
    .mem_store_data (mem_store_data),
    .mem_rd         (mem_rd),
    .mem_reg_write  (mem_reg_write),
    .mem_load       (mem_load),
    .mem_store      (mem_store)
  );

  mem_writeback i_mem_writeback (
    .clock          (clock),
    .rst_n          (rst_n),
    .mem_addr       (mem_addr),
    .mem_store_data (mem_store_data),
    .mem_rd         (mem_rd),
    .mem_reg_write  (mem_reg_write),
    .mem_load       (mem_load),
    .mem_store      (mem_store),
    .dmem_rdata     (dmem_rdata),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_we        (dmem_we),
    .dmem_re        (dmem_re),
    .mem_result     (mem_result),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

endmodule

`default_nettype wire

// File: mem_writeback.sv
// memory and writeback stages of the mini_rv core
// drives the data memory, picks load data or ALU result, feeds the register file
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module mem_writeback (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic [`XLEN-1:0]       mem_addr,
  input  logic [`XLEN-1:0]       mem_store_data,
  input  logic [`REG_ADDR_W-1:0] mem_rd,
  input  logic                   mem_reg_write,
  input  logic                   mem_load,
  input  logic                   mem_store,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic [`XLEN-1:0]       dmem_addr,
  output logic [`XLEN-1:0]       dmem_wdata,
  output logic                   dmem_we,
  output logic                   dmem_re,
  output logic [`XLEN-1:0]       mem_result,
  output logic                   wb_we,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  assign dmem_addr  = mem_addr;
  assign dmem_wdata = mem_store_data;
  assign dmem_we    = mem_store; // written at the next edge
  assign dmem_re    = mem_load;

  // read data is combinational, so loads forward from here
  assign mem_result = mem_load ? dmem_rdata : mem_addr;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      wb_we <= 1'b0;
    else
      wb_we <= mem_reg_write;
  end

  always_ff @(posedge clock)
  begin
    wb_rd   <= mem_rd;
    wb_data <= mem_result;
  end

endmodule

`default_nettype wire

// File: execute_unit.sv
// execute stage of the mini_rv core
// ALU, beq/bne resolution with redirect, and the execute-to-memory register
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module execute_unit import core_pipe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic [`XLEN-1:0]       ex_pc,
  input  logic [`XLEN-1:0]       ex_rs1_val,
  input  logic [`XLEN-1:0]       ex_rs2_val,
  input  logic [`XLEN-1:0]       ex_imm,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  alu_op_e                ex_alu_op,
  input  logic                   ex_use_imm,
  input  logic                   ex_reg_write,
  input  logic                   ex_load,
  input  logic                   ex_store,
  input  logic                   ex_branch,
  input  logic                   ex_branch_ne,
  output logic [`XLEN-1:0]       ex_result,
  output logic                   redirect,
  output logic [`XLEN-1:0]       redirect_pc,
  output logic [`XLEN-1:0]       mem_addr,
  output logic [`XLEN-1:0]       mem_store_data,
  output logic [`REG_ADDR_W-1:0] mem_rd,
  output logic                   mem_reg_write,
  output logic                   mem_load,
  output logic                   mem_store
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;

  assign op_a  = ex_rs1_val;
  assign op_b  = ex_use_imm ? ex_imm : ex_rs2_val;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (ex_alu_op)
      ALU_ADD:    ex_result = op_a + op_b;
      ALU_SUB:    ex_result = op_a - op_b;
      ALU_AND:    ex_result = op_a & op_b;
      ALU_OR:     ex_result = op_a | op_b;
      ALU_XOR:    ex_result = op_a ^ op_b;
      ALU_SLT:    ex_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   ex_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:    ex_result = op_a << shamt;
      ALU_SRL:    ex_result = op_a >> shamt;
      ALU_SRA:    ex_result = $signed(op_a) >>> shamt;
      ALU_PASS_B: ex_result = op_b;
      default:    ex_result = '0;
    endcase
  end

  // beq and bne always compare the two registers
  assign redirect    = ex_branch && ((ex_rs1_val == ex_rs2_val) != ex_branch_ne);
  assign redirect_pc = ex_pc + ex_imm;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      mem_reg_write <= 1'b0;
      mem_load      <= 1'b0;
      mem_store     <= 1'b0;
    end
    else
    begin
      mem_reg_write <= ex_reg_write;
      mem_load      <= ex_load;
      mem_store     <= ex_store;
    end
  end

  always_ff @(posedge clock)
  begin
    mem_addr       <= ex_result; // also the ALU result for writeback
    mem_store_data <= ex_rs2_val;
    mem_rd         <= ex_rd;
  end

endmodule

`default_nettype wire

// File: hazard_unit.sv
// hazard detection for the mini_rv core
// forwarding source per operand and the load-use stall
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module hazard_unit import rv_isa_pkg::*, core_pipe_pkg::*; (
  input  instr_u                 id_instr,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  logic [`REG_ADDR_W-1:0] mem_rd,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic                   ex_reg_write,
  input  logic                   mem_reg_write,
  input  logic                   wb_we,
  input  logic                   ex_load,
  output logic                   stall,
  output fwd_sel_e               fwd_rs1,
  output fwd_sel_e               fwd_rs2
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;

  // youngest writer wins, x0 never forwards
  function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs);
    if (rs == '0)
      pick_src = FWD_REG;
    else if (ex_reg_write && ex_rd == rs)
      pick_src = FWD_EX;
    else if (mem_reg_write && mem_rd == rs)
      pick_src = FWD_MEM;
    else if (wb_we && wb_rd == rs)
      pick_src = FWD_WB;
    else
      pick_src = FWD_REG;
  endfunction

  assign rs1 = id_instr.r_fmt.rs1;
  assign rs2 = id_instr.r_fmt.rs2;

  always_comb
  begin
    fwd_rs1 = pick_src(rs1);
    fwd_rs2 = pick_src(rs2);
  end

  // load data only exists a stage later
  assign stall = ex_load && (ex_rd != '0) && (ex_rd == rs1 || ex_rd == rs2);

endmodule

`default_nettype wire

// File: decode_unit.sv
// decode stage of the mini_rv core
// register file, immediate and control decode, operand forwarding,
// and the decode-to-execute register
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module decode_unit import rv_isa_pkg::*, core_pipe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic                   flush,
  input  instr_u                 id_instr,
  input  logic [`XLEN-1:0]       id_pc,
  input  fwd_sel_e               fwd_rs1,
  input  fwd_sel_e               fwd_rs2,
  input  logic [`XLEN-1:0]       ex_result,
  input  logic [`XLEN-1:0]       mem_result,
  input  logic                   wb_we,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       ex_pc,
  output logic [`XLEN-1:0]       ex_rs1_val,
  output logic [`XLEN-1:0]       ex_rs2_val,
  output logic [`XLEN-1:0]       ex_imm,
  output logic [`REG_ADDR_W-1:0] ex_rd,
  output alu_op_e                ex_alu_op,
  output logic                   ex_use_imm,
  output logic                   ex_reg_write,
  output logic                   ex_load,
  output logic                   ex_store,
  output logic                   ex_branch,
  output logic                   ex_branch_ne
);

  logic [`XLEN-1:0]       regs [`NUM_REGS];
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`XLEN-1:0]       rs1_reg;
  logic [`XLEN-1:0]       rs2_reg;
  logic [6:0]             funct7;
  logic [4:0]             rd_f;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_s;
  logic [`XLEN-1:0]       imm_b;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       imm;
  logic                   alt;
  alu_op_e                alu_op;
  logic                   use_imm;
  logic                   reg_write;
  logic                   load;
  logic                   store;
  logic                   branch;

  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [`XLEN-1:0] reg_val);
    case (sel)
      FWD_EX:  fwd_mux = ex_result;
      FWD_MEM: fwd_mux = mem_result;
      FWD_WB:  fwd_mux = wb_data;
      default: fwd_mux = reg_val;
    endcase
  endfunction

  always_ff @(posedge clock)
  begin
    if (wb_we && wb_rd != '0)
      regs[wb_rd] <= wb_data;
  end

  assign rs1     = id_instr.r_fmt.rs1;
  assign rs2     = id_instr.r_fmt.rs2;
  assign rs1_reg = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
  assign rs2_reg = (rs2 == '0) ? '0 : regs[rs2];

  assign funct7 = id_instr.r_fmt.funct7;
  assign rd_f   = id_instr.r_fmt.rd;
  assign alt    = (funct7 == F7_ALT);

  assign imm_i = {{20{id_instr.i_fmt.imm12[11]}}, id_instr.i_fmt.imm12};
  assign imm_s = {{20{funct7[6]}}, funct7, rd_f};
  assign imm_b = {{20{funct7[6]}}, rd_f[0], funct7[5:0], rd_f[4:1], 1'b0};
  assign imm_u = {id_instr.i_fmt.imm12, id_instr.i_fmt.rs1, id_instr.i_fmt.funct3, 12'b0};

  always_comb
  begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    branch    = 1'b0;
    case (id_instr.r_fmt.opcode)
      OPC_OP, OPC_OP_IMM:
      begin
        use_imm   = (id_instr.r_fmt.opcode == OPC_OP_IMM);
        reg_write = 1'b1;
        case (id_instr.r_fmt.funct3)
          F3_ADD_SUB: alu_op = (alt && !use_imm) ? ALU_SUB : ALU_ADD; // no subi
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
        endcase
      end
      OPC_LUI:
      begin
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OPC_LOAD:
      begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        load      = 1'b1;
      end
      OPC_STORE:
      begin
        imm     = imm_s;
        use_imm = 1'b1;
        store   = 1'b1;
      end
      OPC_BRANCH:
      begin
        imm    = imm_b;
        branch = 1'b1;
      end
      default: ; // anything else passes as a bubble
    endcase
  end

  // control bits drop to a bubble on stall or flush
  always_ff @(posedge clock)
  begin
    if (!rst_n || stall || flush)
    begin
      ex_reg_write <= 1'b0;
      ex_load      <= 1'b0;
      ex_store     <= 1'b0;
      ex_branch    <= 1'b0;
    end
    else
    begin
      ex_reg_write <= reg_write;
      ex_load      <= load;
      ex_store     <= store;
      ex_branch    <= branch;
    end
  end

  always_ff @(posedge clock)
  begin
    ex_pc        <= id_pc;
    ex_rs1_val   <= fwd_mux(fwd_rs1, rs1_reg);
    ex_rs2_val   <= fwd_mux(fwd_rs2, rs2_reg);
    ex_imm       <= imm;
    ex_rd        <= rd_f;
    ex_alu_op    <= alu_op;
    ex_use_imm   <= use_imm;
    ex_branch_ne <= (id_instr.r_fmt.funct3 == F3_BNE);
  end

endmodule

`default_nettype wire

// File: fetch_issue.sv
// fetch stage of the mini_rv core
// program counter with launch, redirect and stall, and the fetch-to-decode register
`timescale 1ns/1ns
`default_nettype none
`include "mini_rv_cfg.svh"

module fetch_issue import rv_isa_pkg::*; (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             running,
  input  logic             launch,
  input  logic             stall,
  input  logic             redirect,
  input  logic [`XLEN-1:0] program_address,
  input  logic [`XLEN-1:0] redirect_pc,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] imem_addr,
  output instr_u           id_instr,
  output logic [`XLEN-1:0] id_pc
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] fetch_pc;

  // launch cycle fetches straight from the start address
  assign fetch_pc  = launch ? program_address : pc;
  assign imem_addr = fetch_pc;

  always_ff @(posedge clock)
  begin
    if (!rst_n || !running)
      pc <= program_address; // track the start address while idle
    else if (redirect)
      pc <= redirect_pc;
    else if (!stall)
      pc <= fetch_pc + `XLEN'(4);
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n || redirect || !running)
      id_instr <= `NOP_INSTR;
    else if (!stall)
    begin
      id_instr <= imem_data;
      id_pc    <= fetch_pc;
    end
  end

endmodule

`default_nettype wire

// File: run_control.sv
// run control for the mini_rv core
// waits in idle after reset, starts on start and then runs until reset
`timescale 1ns/1ns
`default_nettype none

module run_control (
  input  logic clock,
  input  logic rst_n,
  input  logic start,
  output logic running,
  output logic launch
);

  typedef enum logic {IDLE, RUN} state_e;

  state_e state;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      state  <= IDLE;
      launch <= 1'b0;
    end
    else
    begin
      launch <= 1'b0;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            state  <= RUN;
            launch <= 1'b1; // first run cycle
          end
        end
        RUN:  state <= RUN;
      endcase
    end
  end

  assign running = (state == RUN);

endmodule

`default_nettype wire

// File: core_pipe_pkg.sv
// pipeline types shared between the mini_rv stages
// ALU operation codes and forwarding source selects
`default_nettype none

package core_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_EX,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
// RV32I encoding for the mini_rv subset
// opcodes, funct fields and the field layouts of one instruction word
`default_nettype none

package rv_isa_pkg;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010; // lw and sw

  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000; // sub, sra, srai

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // store and branch immediates come from r_fmt funct7 and rd
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

endpackage

`default_nettype wire

// File: mini_rv_cfg.svh
// mini_rv core configuration
// datapath and register file sizes, plus the bubble encoding
`ifndef MINI_RV_CFG_SVH
`define MINI_RV_CFG_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32

// addi x0, x0, 0 used as the pipeline bubble
`define NOP_INSTR  32'h0000_0013

`endif
